//--- design/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// issue queue geometry
`define IQ_DEPTH 8

// slot index width, log2 of IQ_DEPTH
`define SLOT_W 3

// physical register file
`define PREG_COUNT 64

`define PREG_W 6

// operand and result width
`define DATA_W 32

// reorder buffer tag
`define ROB_W 5

`endif

//--- design/issue_pkg.sv
`default_nettype none

`include "issue_consts.svh"

package issue_pkg;

    // execute lane is derived from the class
    typedef enum logic [1:0] {
        op_alu1 = 2'd0,
        op_br   = 2'd1,
        op_alu2 = 2'd2
    } op_class_e;

    typedef struct packed {
        logic                valid;
        op_class_e           op_class;
        logic [`PREG_W-1:0]  src1;
        logic [`PREG_W-1:0]  src2;
        logic [`PREG_W-1:0]  dest;
        logic                rf_we;
        logic                src1_ready;
        logic                src2_ready;
        logic [`ROB_W-1:0]   rob;
    } dispatch_t;

    typedef struct packed {
        logic                rf_we;
        logic [`PREG_W-1:0]  dest;
        logic [`DATA_W-1:0]  result;
    } wb_t;

    // ready bits change while the entry waits
    typedef struct packed {
        logic                valid;
        op_class_e           op_class;
        logic [`PREG_W-1:0]  src1;
        logic [`PREG_W-1:0]  src2;
        logic [`PREG_W-1:0]  dest;
        logic                rf_we;
        logic                src1_ready;
        logic                src2_ready;
        logic [`ROB_W-1:0]   rob;
    } iq_entry_t;

    typedef struct packed {
        logic                valid;
        op_class_e           op_class;
        logic [`PREG_W-1:0]  dest;
        logic                rf_we;
        logic [`ROB_W-1:0]   rob;
        logic [`DATA_W-1:0]  src1_value;
        logic [`DATA_W-1:0]  src2_value;
    } issue_t;

endpackage

`default_nettype wire

//--- design/iq_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module iq_slot (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 load,
    input  issue_pkg::dispatch_t load_data,
    input  logic                 clear,
    input  issue_pkg::wb_t       wb0,
    input  issue_pkg::wb_t       wb1,
    output issue_pkg::iq_entry_t entry
);

    logic                 occupied_q;
    issue_pkg::iq_entry_t data_q;
    logic [`PREG_W-1:0]   src1_cmp;
    logic [`PREG_W-1:0]   src2_cmp;
    logic                 wake1;
    logic                 wake2;

    function automatic logic wb_hit(issue_pkg::wb_t wb, logic [`PREG_W-1:0] src);
        // register 0 is never written back
        return wb.rf_we && (wb.dest != '0) && (wb.dest == src);
    endfunction

    // compare against incoming sources on load so a same-cycle writeback is not missed
    assign src1_cmp = load ? load_data.src1 : data_q.src1;
    assign src2_cmp = load ? load_data.src2 : data_q.src2;
    assign wake1    = wb_hit(wb0, src1_cmp) || wb_hit(wb1, src1_cmp);
    assign wake2    = wb_hit(wb0, src2_cmp) || wb_hit(wb1, src2_cmp);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupied_q <= 1'b0;
        end else if (flush || clear) begin
            occupied_q <= 1'b0;
        end else if (load) begin
            occupied_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q            <= load_data;
            data_q.src1_ready <= load_data.src1_ready || wake1;
            data_q.src2_ready <= load_data.src2_ready || wake2;
        end else if (occupied_q) begin
            data_q.src1_ready <= data_q.src1_ready || wake1;
            data_q.src2_ready <= data_q.src2_ready || wake2;
        end
    end

    always_comb begin
        entry       = data_q;
        entry.valid = occupied_q;
    end

endmodule

`default_nettype wire

//--- design/iq_alloc.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module iq_alloc (
    input  logic [`IQ_DEPTH-1:0] occupied,
    input  logic                 dispatch0_valid,
    input  logic                 dispatch1_valid,
    output logic [`IQ_DEPTH-1:0] load0,
    output logic [`IQ_DEPTH-1:0] load1,
    output logic                 dispatch_ready
);

    logic [`IQ_DEPTH-1:0] first_free;
    logic [`IQ_DEPTH-1:0] second_free;
    logic [`SLOT_W:0]     free_cnt;

    // one-hot masks of the two lowest free slots, plus a free count
    always_comb begin
        first_free  = '0;
        second_free = '0;
        free_cnt    = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (!occupied[i]) begin
                if (free_cnt == '0) begin
                    first_free[i] = 1'b1;
                end else if (free_cnt == (`SLOT_W+1)'(1)) begin
                    second_free[i] = 1'b1;
                end
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    // two slots must be free so both ports can always be taken
    assign dispatch_ready = (free_cnt >= (`SLOT_W+1)'(2));

    // port 0 gets the lowest slot, port 1 the next one up
    always_comb begin
        load0 = '0;
        load1 = '0;
        if (dispatch_ready) begin
            if (dispatch0_valid) begin
                load0 = first_free;
            end
            if (dispatch1_valid) begin
                load1 = second_free;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/iq_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module iq_select (
    input  issue_pkg::iq_entry_t entries [`IQ_DEPTH],
    input  logic                 alu1_allowin,
    input  logic                 bru_allowin,
    input  logic                 alu2_allowin,
    output logic [`IQ_DEPTH-1:0] clear,
    output issue_pkg::iq_entry_t sel0,
    output issue_pkg::iq_entry_t sel1
);

    logic [`IQ_DEPTH-1:0] cand0;
    logic [`IQ_DEPTH-1:0] cand1;
    logic                 found0;
    logic                 found1;
    logic [`SLOT_W-1:0]   idx0;
    logic [`SLOT_W-1:0]   idx1;

    function automatic logic is_ready(issue_pkg::iq_entry_t e);
        return e.valid && e.src1_ready && e.src2_ready;
    endfunction

    // lane candidates, class must match and the unit must accept it
    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            cand0[i] = is_ready(entries[i]) &&
                       ((entries[i].op_class == issue_pkg::op_alu1 && alu1_allowin) ||
                        (entries[i].op_class == issue_pkg::op_br   && bru_allowin));
            cand1[i] = is_ready(entries[i]) &&
                       (entries[i].op_class == issue_pkg::op_alu2 && alu2_allowin);
        end
    end

    // lowest index wins, scan from the top down
    always_comb begin
        found0 = 1'b0;
        found1 = 1'b0;
        idx0   = '0;
        idx1   = '0;
        for (int i = `IQ_DEPTH-1; i >= 0; i--) begin
            if (cand0[i]) begin
                found0 = 1'b1;
                idx0   = `SLOT_W'(i);
            end
            if (cand1[i]) begin
                found1 = 1'b1;
                idx1   = `SLOT_W'(i);
            end
        end
    end

    always_comb begin
        sel0  = '0;
        sel1  = '0;
        clear = '0;
        if (found0) begin
            sel0        = entries[idx0];
            clear[idx0] = 1'b1;
        end
        // classes are disjoint, so idx1 never equals idx0 when both are found
        if (found1) begin
            sel1        = entries[idx1];
            clear[idx1] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module phys_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [`PREG_W-1:0] raddr [4],
    output logic [`DATA_W-1:0] rdata [4],
    input  issue_pkg::wb_t     wb0,
    input  issue_pkg::wb_t     wb1
);

    localparam int RD_PORTS = 4;

    logic [`DATA_W-1:0] regs [`PREG_COUNT];

    // wb1 is written last, so it wins when both ports hit the same register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0.rf_we && wb0.dest != '0) begin
                regs[wb0.dest] <= wb0.result;
            end
            if (wb1.rf_we && wb1.dest != '0) begin
                regs[wb1.dest] <= wb1.result;
            end
        end
    end

    // bypass from the write ports in the same cycle
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (wb1.rf_we && wb1.dest == raddr[p]) begin
                rdata[p] = wb1.result;
            end else if (wb0.rf_we && wb0.dest == raddr[p]) begin
                rdata[p] = wb0.result;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module issue_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  issue_pkg::dispatch_t dispatch0,
    input  issue_pkg::dispatch_t dispatch1,
    input  issue_pkg::wb_t       wb0,
    input  issue_pkg::wb_t       wb1,
    input  logic                 alu1_allowin,
    input  logic                 bru_allowin,
    input  logic                 alu2_allowin,
    output logic                 dispatch_ready,
    output issue_pkg::issue_t    issue0,
    output issue_pkg::issue_t    issue1
);

    issue_pkg::iq_entry_t entries [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] occupied;
    logic [`IQ_DEPTH-1:0] load0;
    logic [`IQ_DEPTH-1:0] load1;
    logic [`IQ_DEPTH-1:0] clear;
    issue_pkg::iq_entry_t sel0;
    issue_pkg::iq_entry_t sel1;
    issue_pkg::iq_entry_t iss0_q;
    issue_pkg::iq_entry_t iss1_q;
    logic                 iss0_valid;
    logic                 iss1_valid;
    logic [`PREG_W-1:0]   rf_raddr [4];
    logic [`DATA_W-1:0]   rf_rdata [4];

    function automatic issue_pkg::issue_t make_issue(
        logic                 vld,
        issue_pkg::iq_entry_t e,
        logic [`DATA_W-1:0]   v1,
        logic [`DATA_W-1:0]   v2
    );
        issue_pkg::issue_t r;
        r.valid      = vld;
        r.op_class   = e.op_class;
        r.dest       = e.dest;
        r.rf_we      = e.rf_we;
        r.rob        = e.rob;
        r.src1_value = v1;
        r.src2_value = v2;
        return r;
    endfunction

    // slot array, loads from either dispatch port
    for (genvar i = 0; i < `IQ_DEPTH; i++) begin : g_slot
        iq_slot i_iq_slot (
            .clk       (clk),
            .arst_n    (arst_n),
            .flush     (flush),
            .load      (load0[i] || load1[i]),
            .load_data (load0[i] ? dispatch0 : dispatch1),
            .clear     (clear[i]),
            .wb0       (wb0),
            .wb1       (wb1),
            .entry     (entries[i])
        );
        assign occupied[i] = entries[i].valid;
    end

    iq_alloc i_iq_alloc (
        .occupied        (occupied),
        .dispatch0_valid (dispatch0.valid),
        .dispatch1_valid (dispatch1.valid),
        .load0           (load0),
        .load1           (load1),
        .dispatch_ready  (dispatch_ready)
    );

    iq_select i_iq_select (
        .entries      (entries),
        .alu1_allowin (alu1_allowin),
        .bru_allowin  (bru_allowin),
        .alu2_allowin (alu2_allowin),
        .clear        (clear),
        .sel0         (sel0),
        .sel1         (sel1)
    );

    // issue register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss0_valid <= 1'b0;
            iss1_valid <= 1'b0;
        end else if (flush) begin
            iss0_valid <= 1'b0;
            iss1_valid <= 1'b0;
        end else begin
            iss0_valid <= sel0.valid;
            iss1_valid <= sel1.valid;
        end
    end

    always_ff @(posedge clk) begin
        iss0_q <= sel0;
        iss1_q <= sel1;
    end

    assign rf_raddr[0] = iss0_q.src1;
    assign rf_raddr[1] = iss0_q.src2;
    assign rf_raddr[2] = iss1_q.src1;
    assign rf_raddr[3] = iss1_q.src2;

    phys_regfile i_phys_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (rf_raddr),
        .rdata  (rf_rdata),
        .wb0    (wb0),
        .wb1    (wb1)
    );

    assign issue0 = make_issue(iss0_valid, iss0_q, rf_rdata[0], rf_rdata[1]);
    assign issue1 = make_issue(iss1_valid, iss1_q, rf_rdata[2], rf_rdata[3]);

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/issue_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_consts.svh"

module issue_stage_tb;

    localparam int RUN_CYCLES    = 3000;
    localparam int ISSUE_TIMEOUT = 300;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int RESET_TIMEOUT = 100;
    localparam int TAGS          = 1 << `ROB_W;

    typedef struct packed {
        logic [`PREG_W-1:0] dest;
        logic [31:0]        due;
    } pending_wb_t;

    logic                 clk;
    logic                 arst_n;
    logic                 flush;
    issue_pkg::dispatch_t dispatch0;
    issue_pkg::dispatch_t dispatch1;
    issue_pkg::wb_t       wb0;
    issue_pkg::wb_t       wb1;
    logic                 alu1_allowin;
    logic                 bru_allowin;
    logic                 alu2_allowin;
    logic                 dispatch_ready;
    issue_pkg::issue_t    issue0;
    issue_pkg::issue_t    issue1;

    // renamer and execute model
    logic [`DATA_W-1:0]   model_rf [`PREG_COUNT];
    logic                 busy     [`PREG_COUNT];
    logic                 busy_pre [`PREG_COUNT];
    int                   wb_cycle [`PREG_COUNT];
    logic                 queued   [TAGS];
    issue_pkg::dispatch_t rec      [TAGS];
    int                   disp_cycle [TAGS];
    logic                 allow_prev [3];
    pending_wb_t          wb_q [$];
    logic                 cleared;
    logic                 reset_ok;
    logic                 drained;
    int                   cycle;
    int                   errors;
    int                   checks;

    tb_clk_gen i_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    issue_stage i_issue_stage (
        .clk            (clk),
        .arst_n         (arst_n),
        .flush          (flush),
        .dispatch0      (dispatch0),
        .dispatch1      (dispatch1),
        .wb0            (wb0),
        .wb1            (wb1),
        .alu1_allowin   (alu1_allowin),
        .bru_allowin    (bru_allowin),
        .alu2_allowin   (alu2_allowin),
        .dispatch_ready (dispatch_ready),
        .issue0         (issue0),
        .issue1         (issue1)
    );

    task automatic check(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    task automatic check_value(input string name, input logic [`DATA_W-1:0] got,
                               input logic [`DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // free, not read by a waiting instruction, not written back this cycle
    function automatic logic [`PREG_W-1:0] pick_dest();
        logic [`PREG_W-1:0] r;
        logic               used;
        r = `PREG_W'($urandom);
        for (int n = 0; n < `PREG_COUNT; n++) begin
            used = (r == '0) || busy[r] ||
                   (wb0.rf_we && wb0.dest == r) || (wb1.rf_we && wb1.dest == r);
            for (int t = 0; t < TAGS; t++) begin
                if (queued[t] && (rec[t].src1 == r || rec[t].src2 == r)) begin
                    used = 1'b1;
                end
            end
            if (!used) begin
                return r;
            end
            r = r + 1'b1;
        end
        return '0;
    endfunction

    function automatic logic [`PREG_W-1:0] pick_src();
        if ($urandom_range(7) == 0) begin
            return '0;
        end
        return `PREG_W'($urandom);
    endfunction

    task automatic new_instr(output issue_pkg::dispatch_t d);
        logic [`ROB_W-1:0] tag;
        tag = `ROB_W'($urandom);
        for (int n = 0; n < TAGS && queued[tag]; n++) begin
            tag = tag + 1'b1;
        end
        d            = '0;
        d.valid      = 1'b1;
        d.op_class   = issue_pkg::op_class_e'($urandom_range(2));
        d.src1       = pick_src();
        d.src2       = pick_src();
        d.src1_ready = !busy_pre[d.src1];
        d.src2_ready = !busy_pre[d.src2];
        d.rob        = tag;
        queued[tag]  = 1'b1;
        rec[tag]     = d;
        disp_cycle[tag] = cycle;
        d.dest  = pick_dest();
        d.rf_we = (d.dest != '0) && ($urandom_range(7) != 0);
        if (!d.rf_we) begin
            d.dest = '0;
        end else begin
            busy[d.dest]     = 1'b1;
            busy_pre[d.dest] = 1'b1;
        end
        rec[tag] = d;
    endtask

    task automatic drive_writebacks();
        issue_pkg::wb_t w [2];
        issue_pkg::wb_t tmp;
        int             n;
        int             i;
        w[0] = '0;
        w[1] = '0;
        n    = 0;
        i    = 0;
        while (i < wb_q.size() && n < 2) begin
            if (wb_q[i].due <= cycle) begin
                w[n].rf_we  = 1'b1;
                w[n].dest   = wb_q[i].dest;
                w[n].result = $urandom;
                busy[w[n].dest]     = 1'b0;
                wb_cycle[w[n].dest] = cycle;
                wb_q.delete(i);
                n++;
            end else begin
                i++;
            end
        end
        // extra write to an idle register, or to register zero which keeps its value
        if (n < 2 && $urandom_range(3) == 0) begin
            w[n].rf_we  = 1'b1;
            w[n].dest   = pick_src();
            w[n].result = $urandom;
            if (busy[w[n].dest]) begin
                w[n].dest = '0;
            end
        end
        if ($urandom_range(1) == 1) begin
            tmp  = w[0];
            w[0] = w[1];
            w[1] = tmp;
        end
        // wb1 lands last when both ports name one register
        for (int p = 0; p < 2; p++) begin
            if (w[p].rf_we && w[p].dest != '0) begin
                model_rf[w[p].dest] = w[p].result;
            end
        end
        wb0 = w[0];
        wb1 = w[1];
    endtask

    task automatic check_issue(input int lane, input issue_pkg::issue_t is);
        issue_pkg::dispatch_t d;
        pending_wb_t          p;
        string                nm;
        nm = (lane == 0) ? "issue0" : "issue1";
        if (is.valid) begin
            check(queued[is.rob], $sformatf("%s carries rob tag %0d, which is not waiting",
                                            nm, is.rob));
        end
        if (is.valid && queued[is.rob]) begin
            d = rec[is.rob];
            queued[is.rob] = 1'b0;
            if (lane == 0) begin
                check(is.op_class != issue_pkg::op_alu2, "alu2 op issued on lane 0");
            end else begin
                check(is.op_class == issue_pkg::op_alu2, "alu1 or branch op issued on lane 1");
            end
            check_value({nm, ".op_class"}, is.op_class, d.op_class);
            check_value({nm, ".dest"}, is.dest, d.dest);
            check_value({nm, ".rf_we"}, is.rf_we, d.rf_we);
            check(allow_prev[d.op_class], $sformatf("rob %0d selected while its unit refused it",
                                                    is.rob));
            check(!busy[d.src1] && (d.src1_ready || wb_cycle[d.src1] + 2 <= cycle),
                  $sformatf("rob %0d issued before its first source was written", is.rob));
            check(!busy[d.src2] && (d.src2_ready || wb_cycle[d.src2] + 2 <= cycle),
                  $sformatf("rob %0d issued before its second source was written", is.rob));
            check_value({nm, ".src1_value"}, is.src1_value, model_rf[d.src1]);
            check_value({nm, ".src2_value"}, is.src2_value, model_rf[d.src2]);
            if (d.rf_we) begin
                p.dest = d.dest;
                p.due  = cycle + $urandom_range(1, 4);
                wb_q.push_back(p);
            end
        end
    endtask

    function automatic int count_queued(input logic only_old);
        int n;
        n = 0;
        for (int t = 0; t < TAGS; t++) begin
            if (queued[t] && (!only_old || disp_cycle[t] < cycle)) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic run_cycle(input logic do_flush, input logic may_dispatch);
        issue_pkg::dispatch_t d0;
        issue_pkg::dispatch_t d1;
        logic                 can_disp;
        @(negedge clk);
        cycle++;
        can_disp = dispatch_ready && may_dispatch && !do_flush;
        busy_pre = busy;
        drive_writebacks();
        d0 = '0;
        d1 = '0;
        if (can_disp && $urandom_range(7) < 3) begin
            new_instr(d0);
        end
        if (can_disp && $urandom_range(7) < 3) begin
            new_instr(d1);
        end
        dispatch0    = d0;
        dispatch1    = d1;
        flush        = do_flush;
        alu1_allowin = ($urandom_range(3) != 0);
        bru_allowin  = ($urandom_range(3) != 0);
        alu2_allowin = ($urandom_range(3) != 0);
        #1;
        if (cleared) begin
            check(!issue0.valid && !issue1.valid, "issue valid right after reset or flush");
        end
        check_issue(0, issue0);
        check_issue(1, issue1);
        check_value("dispatch_ready", dispatch_ready,
                    (`IQ_DEPTH - count_queued(1'b1)) >= 2);
        // flushed instructions never write their dest
        if (do_flush) begin
            for (int t = 0; t < TAGS; t++) begin
                if (queued[t] && rec[t].rf_we) begin
                    busy[rec[t].dest] = 1'b0;
                end
                queued[t] = 1'b0;
            end
        end
        for (int t = 0; t < TAGS; t++) begin
            if (queued[t] && cycle - disp_cycle[t] > ISSUE_TIMEOUT) begin
                check(1'b0, $sformatf("rob %0d not issued within %0d cycles", t, ISSUE_TIMEOUT));
                queued[t] = 1'b0;
            end
        end
        cleared       = do_flush;
        allow_prev[0] = alu1_allowin;
        allow_prev[1] = bru_allowin;
        allow_prev[2] = alu2_allowin;
    endtask

    initial begin
        void'($urandom(32'ha9e1_b770));
        flush        = 1'b0;
        dispatch0    = '0;
        dispatch1    = '0;
        wb0          = '0;
        wb1          = '0;
        alu1_allowin = 1'b0;
        bru_allowin  = 1'b0;
        alu2_allowin = 1'b0;
        for (int r = 0; r < `PREG_COUNT; r++) begin
            model_rf[r] = '0;
            busy[r]     = 1'b0;
            wb_cycle[r] = -10;
        end
        for (int t = 0; t < TAGS; t++) begin
            queued[t] = 1'b0;
        end
        allow_prev = '{1'b0, 1'b0, 1'b0};
        cleared    = 1'b1;
        cycle      = 0;
        errors     = 0;
        checks     = 0;
        drained    = 1'b0;
        reset_ok   = 1'b0;
        for (int n = 0; n < RESET_TIMEOUT && !reset_ok; n++) begin
            @(posedge clk);
            reset_ok = arst_n;
        end
        check(reset_ok, "reset was never released");
        if (reset_ok) begin
            // quiet window every 64 cycles lets high slots drain
            for (int k = 0; k < RUN_CYCLES; k++) begin
                run_cycle(k % 700 == 350, k % 64 < 48);
            end
            for (int n = 0; n < DRAIN_TIMEOUT && !drained; n++) begin
                run_cycle(1'b0, 1'b0);
                drained = (count_queued(1'b0) == 0) && (wb_q.size() == 0);
            end
            check(drained, "queue did not drain at the end of the run");
        end
        $display("issue_stage_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- issue_stage.f
+incdir+design
design/issue_pkg.sv
design/iq_slot.sv
design/iq_alloc.sv
design/iq_select.sv
design/phys_regfile.sv
design/issue_stage.sv
bench/tb_clk_gen.sv
bench/issue_stage_tb.sv

//--- Bender.yml
package:
  name: issue_stage

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/issue_pkg.sv
      - design/iq_slot.sv
      - design/iq_alloc.sv
      - design/iq_select.sv
      - design/phys_regfile.sv
      - design/issue_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_clk_gen.sv
      - bench/issue_stage_tb.sv
